// File: eth_rx_frame_fifo.f
src/eth_stream_pkg.sv
src/rx_status_pkg.sv
src/rx_frame_check.sv
src/rx_frame_buffer.sv
src/rx_output_pipe.sv
src/eth_rx_frame_fifo.sv
verif/tb_eth_rx_frame_fifo.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it, and checks the log for the pass line
set -e

cd "$(dirname "$0")"

TOP=tb_eth_rx_frame_fifo
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module "$TOP" \
    -f eth_rx_frame_fifo.f \
    -o "$TOP"

./obj_dir/"$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qF 'All tests passed!' "$LOG"; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi

// File: src/eth_rx_frame_fifo.sv
// Single clock receive path; input is never stalled, so frames are dropped when the buffer fills
`timescale 1ns/10ps
`default_nettype none

module eth_rx_frame_fifo #(
    parameter int DEPTH           = 64,
    parameter int MAX_FRAME_BEATS = 190
) (
    input  wire                          logic_clk,
    input  wire                          logic_rst,

    // MAC side
    input  wire eth_stream_pkg::rx_beat_t mac_beat,
    input  wire                          mac_valid,

    // Stream output
    output eth_stream_pkg::rx_beat_t     rx_beat,
    output logic                         rx_valid,
    input  wire                          rx_ready,

    output rx_status_pkg::frame_status_t rx_status
);

    eth_stream_pkg::rx_beat_t chk_beat;
    logic                     chk_valid;
    eth_stream_pkg::rx_beat_t buf_beat;
    logic                     buf_valid;
    logic                     buf_ready;

    rx_frame_check #(
        .MAX_FRAME_BEATS(MAX_FRAME_BEATS)
    ) u_check (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .mac_beat(mac_beat),
        .mac_valid(mac_valid),
        .chk_beat(chk_beat),
        .chk_valid(chk_valid)
    );

    rx_frame_buffer #(
        .DEPTH(DEPTH)
    ) u_buffer (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .chk_beat(chk_beat),
        .chk_valid(chk_valid),
        .buf_beat(buf_beat),
        .buf_valid(buf_valid),
        .buf_ready(buf_ready),
        .rx_status(rx_status)
    );

    rx_output_pipe u_pipe (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .buf_beat(buf_beat),
        .buf_valid(buf_valid),
        .buf_ready(buf_ready),
        .rx_beat(rx_beat),
        .rx_valid(rx_valid),
        .rx_ready(rx_ready)
    );

endmodule

`default_nettype wire

// File: src/eth_stream_pkg.sv
// Beat format fixed at 64-bit data with byte enables; bad is only meaningful on a last beat
`default_nettype none

package eth_stream_pkg;

    // Payload of one beat, same width as the MAC side
    typedef logic [63:0] data_t;

    // One enable per byte of data_t
    typedef logic [7:0] keep_t;

    // Beat as carried between all stages
    // bad on a last beat marks the whole frame for dropping
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        logic  bad;
    } rx_beat_t;

    // Length checker states
    typedef enum logic [1:0] {
        CHECK_IDLE     = 2'd0,
        CHECK_BODY     = 2'd1,
        CHECK_OVERSIZE = 2'd2
    } check_state_t;

endpackage

`default_nettype wire

// File: src/rx_frame_buffer.sv
// DEPTH must be a power of two; a frame larger than free space is dropped whole, never truncated
`timescale 1ns/10ps
`default_nettype none

module rx_frame_buffer #(
    parameter int DEPTH = 64
) (
    input  wire                          logic_clk,
    input  wire                          logic_rst,

    input  wire eth_stream_pkg::rx_beat_t chk_beat,
    input  wire                          chk_valid,

    output eth_stream_pkg::rx_beat_t     buf_beat,
    output logic                         buf_valid,
    input  wire                          buf_ready,

    output rx_status_pkg::frame_status_t rx_status
);

    localparam int ADDR_W = $clog2(DEPTH);

    // Extra bit tells full from empty
    typedef logic [ADDR_W:0]   ptr_t;
    typedef logic [ADDR_W-1:0] addr_t;

    eth_stream_pkg::rx_beat_t mem [DEPTH];

    ptr_t                     rd_ptr;
    ptr_t                     wr_ptr;
    ptr_t                     wr_ptr_commit;
    ptr_t                     wr_ptr_next;
    ptr_t                     used;
    logic                     full;
    logic                     frame_ready;
    logic                     load_out;
    rx_status_pkg::wr_state_t wr_state;

    assign wr_ptr_next = wr_ptr + ptr_t'(1);

    // Occupancy seen by the writer, speculative beats included
    assign used = wr_ptr - rd_ptr;
    assign full = used == ptr_t'(DEPTH);

    // Only committed beats are visible to the reader
    assign frame_ready = rd_ptr != wr_ptr_commit;
    assign load_out    = frame_ready && (!buf_valid || buf_ready);

    // Write side and status
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr        <= '0;
            wr_ptr_commit <= '0;
            wr_state      <= rx_status_pkg::WR_ACCEPT;
            rx_status     <= '0;
        end else begin
            rx_status <= '0;
            if (chk_valid) begin
                if (wr_state == rx_status_pkg::WR_DISCARD || full) begin
                    if (chk_beat.last) begin
                        // Frame lost for space, rewind to the last commit
                        wr_ptr             <= wr_ptr_commit;
                        wr_state           <= rx_status_pkg::WR_ACCEPT;
                        rx_status.overflow <= 1'b1;
                    end else begin
                        wr_state <= rx_status_pkg::WR_DISCARD;
                    end
                end else if (chk_beat.last && chk_beat.bad) begin
                    wr_ptr              <= wr_ptr_commit;
                    rx_status.bad_frame <= 1'b1;
                end else if (chk_beat.last) begin
                    wr_ptr               <= wr_ptr_next;
                    wr_ptr_commit        <= wr_ptr_next;
                    rx_status.good_frame <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr_next;
                end
            end
        end
    end

    // RAM write, payload only
    always_ff @(posedge logic_clk) begin
        if (chk_valid && wr_state == rx_status_pkg::WR_ACCEPT && !full) begin
            mem[addr_t'(wr_ptr)] <= chk_beat;
        end
    end

    // Read side control
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr    <= '0;
            buf_valid <= 1'b0;
        end else begin
            if (load_out) begin
                rd_ptr    <= rd_ptr + ptr_t'(1);
                buf_valid <= 1'b1;
            end else if (buf_ready) begin
                buf_valid <= 1'b0;
            end
        end
    end

    // Output register, refilled as soon as the held beat is taken
    always_ff @(posedge logic_clk) begin
        if (load_out) begin
            buf_beat     <= mem[addr_t'(rd_ptr)];
            // Committed frames carry no error
            buf_beat.bad <= 1'b0;
        end
    end

    // Speculative pointer stays within one buffer of the commit point
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        ptr_t'(wr_ptr - wr_ptr_commit) <= ptr_t'(DEPTH))
        else $error("rx_frame_buffer: commit pointer passed write pointer");

    assert property (@(posedge logic_clk) disable iff (logic_rst)
        $onehot0(rx_status))
        else $error("rx_frame_buffer: more than one status pulse");

endmodule

`default_nettype wire

// File: src/rx_frame_check.sv
// MAC side cannot stall; beats past MAX_FRAME_BEATS are swallowed except the flagged last beat
`timescale 1ns/10ps
`default_nettype none

module rx_frame_check #(
    parameter int MAX_FRAME_BEATS = 190
) (
    input  wire                       logic_clk,
    input  wire                       logic_rst,

    input  wire eth_stream_pkg::rx_beat_t mac_beat,
    input  wire                       mac_valid,

    output eth_stream_pkg::rx_beat_t  chk_beat,
    output logic                      chk_valid
);

    // Must hold MAX_FRAME_BEATS + 1 without wrapping
    localparam int CNT_W = $clog2(MAX_FRAME_BEATS + 2);

    typedef logic [CNT_W-1:0] count_t;

    eth_stream_pkg::check_state_t state;
    count_t                       beat_count;
    count_t                       next_count;
    logic                         too_long;
    logic                         frame_bad;

    // beat_count is zero between frames, so a first beat counts as one
    assign next_count = beat_count + count_t'(1);
    assign too_long   = next_count > count_t'(MAX_FRAME_BEATS);

    // Length flag, plus the MAC error when it comes on a last beat
    assign frame_bad = (mac_beat.last && mac_beat.bad) || too_long ||
                       (state == eth_stream_pkg::CHECK_OVERSIZE);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state      <= eth_stream_pkg::CHECK_IDLE;
            beat_count <= '0;
            chk_valid  <= 1'b0;
        end else begin
            chk_valid <= 1'b0;
            if (mac_valid) begin
                if (mac_beat.last) begin
                    // End of frame always passes so the buffer can close it
                    chk_valid  <= 1'b1;
                    state      <= eth_stream_pkg::CHECK_IDLE;
                    beat_count <= '0;
                end else if (state == eth_stream_pkg::CHECK_OVERSIZE) begin
                    // Swallow body beats of a long frame
                    state <= eth_stream_pkg::CHECK_OVERSIZE;
                end else if (too_long) begin
                    state <= eth_stream_pkg::CHECK_OVERSIZE;
                end else begin
                    chk_valid  <= 1'b1;
                    state      <= eth_stream_pkg::CHECK_BODY;
                    beat_count <= next_count;
                end
            end
        end
    end

    // Payload register
    always_ff @(posedge logic_clk) begin
        if (mac_valid) begin
            chk_beat.data <= mac_beat.data;
            chk_beat.keep <= mac_beat.keep;
            chk_beat.last <= mac_beat.last;
            // Length flag only rises on beats that are swallowed or end the frame
            chk_beat.bad  <= frame_bad;
        end
    end

    // Buffer decides drops from the last beat alone, so body beats must be clean
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        chk_valid |-> !(chk_beat.bad && !chk_beat.last))
        else $error("rx_frame_check: bad flag on a non-last beat");

endmodule

`default_nettype wire

// File: src/rx_output_pipe.sv
// buf_ready depends combinationally on rx_ready; two beats in flight at most
`timescale 1ns/10ps
`default_nettype none

module rx_output_pipe (
    input  wire                          logic_clk,
    input  wire                          logic_rst,

    input  wire eth_stream_pkg::rx_beat_t buf_beat,
    input  wire                          buf_valid,
    output logic                         buf_ready,

    output eth_stream_pkg::rx_beat_t     rx_beat,
    output logic                         rx_valid,
    input  wire                          rx_ready
);

    eth_stream_pkg::rx_beat_t mid_beat;
    logic                     mid_valid;
    logic                     out_open;

    // Output stage can load when empty or being taken
    assign out_open = !rx_valid || rx_ready;

    // First stage can load when empty or moving on
    assign buf_ready = !mid_valid || out_open;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            mid_valid <= 1'b0;
            rx_valid  <= 1'b0;
        end else begin
            if (out_open) begin
                rx_valid <= mid_valid;
            end
            if (buf_ready) begin
                mid_valid <= buf_valid;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (out_open && mid_valid) begin
            rx_beat <= mid_beat;
        end
        if (buf_ready && buf_valid) begin
            mid_beat <= buf_beat;
        end
    end

    // Stream rule on the output
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        (rx_valid && !rx_ready) |=> (rx_valid && $stable(rx_beat)))
        else $error("rx_output_pipe: output changed while stalled");

endmodule

`default_nettype wire

// File: src/rx_status_pkg.sv
// Status bits are single-cycle pulses on logic_clk; at most one is set in any cycle
`default_nettype none

package rx_status_pkg;

    // Frame outcome reported by the buffer
    typedef struct packed {
        logic good_frame;
        logic bad_frame;
        logic overflow;
    } frame_status_t;

    // Write side of the frame buffer
    // WR_DISCARD holds until the last beat of a frame that ran out of space
    typedef enum logic {
        WR_ACCEPT  = 1'b0,
        WR_DISCARD = 1'b1
    } wr_state_t;

endpackage

`default_nettype wire

// File: verif/tb_eth_rx_frame_fifo.sv
// Single clock testbench for DEPTH 32 and a 24-beat frame limit; model holds up to 4096 beats
`timescale 1ns/10ps
`default_nettype none

module tb_eth_rx_frame_fifo;

    localparam int TB_DEPTH  = 32;
    localparam int MAX_BEATS = 24;

    logic                         logic_clk = 1'b0;
    logic                         logic_rst;
    eth_stream_pkg::rx_beat_t     mac_beat;
    logic                         mac_valid;
    eth_stream_pkg::rx_beat_t     rx_beat;
    logic                         rx_valid;
    logic                         rx_ready;
    rx_status_pkg::frame_status_t rx_status;

    // Reference model of beats that must reach the output, in order
    eth_stream_pkg::rx_beat_t exp_mem [4096];
    logic [11:0]              exp_wr;
    logic [11:0]              exp_rd;
    logic [11:0]              pending;
    eth_stream_pkg::rx_beat_t exp_head;
    logic                     exp_present;

    int exp_good;
    int exp_bad;
    int exp_ovf;
    int good_pulses;
    int bad_pulses;
    int ovf_pulses;

    logic                     stall_q;
    eth_stream_pkg::rx_beat_t held_beat;
    logic [15:0]              lfsr_state;
    logic                     random_ready;
    string                    test_name;

    assign pending     = exp_wr - exp_rd;
    assign exp_present = exp_wr != exp_rd;
    assign exp_head    = exp_mem[exp_rd];

    always #10 logic_clk = ~logic_clk;

    eth_rx_frame_fifo #(
        .DEPTH(TB_DEPTH),
        .MAX_FRAME_BEATS(MAX_BEATS)
    ) UUT (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .mac_beat(mac_beat),
        .mac_valid(mac_valid),
        .rx_beat(rx_beat),
        .rx_valid(rx_valid),
        .rx_ready(rx_ready),
        .rx_status(rx_status)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string check, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h",
                 test_name, check, expected, actual);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_count(input string check, input int expected, input int actual);
        assert (expected == actual)
            else report_mismatch(check, {96'd0, expected}, {96'd0, actual});
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[62:0], lfsr_state[0]};
        end
    endtask

    // One clock of stimulus, input idle unless the caller drives a beat
    task automatic tick();
        logic [63:0] r;
        @(posedge logic_clk);
        mac_valid <= 1'b0;
        if (random_ready) begin
            take_bits(1, r);
            rx_ready <= r[0];
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            tick();
        end
    endtask

    task automatic set_ready(input logic value);
        tick();
        rx_ready <= value;
    endtask

    task automatic apply_reset();
        logic_rst = 1'b1;
        repeat (8) @(posedge logic_clk);
        logic_rst <= 1'b0;
    endtask

    // Frame passes only when short enough, clean at the MAC and not squeezed out
    task automatic send_frame(input int len, input logic mac_bad, input logic lost_for_space);
        logic [63:0]              r;
        logic [63:0]              k;
        eth_stream_pkg::rx_beat_t b;
        logic                     pass;
        pass = (len <= MAX_BEATS) && !mac_bad && !lost_for_space;
        for (int i = 0; i < len; i++) begin
            take_bits(64, r);
            take_bits(8, k);
            b.data = r;
            b.last = (i == len - 1);
            b.keep = b.last ? (k[7:0] | 8'h01) : 8'hff;
            b.bad  = b.last && mac_bad;
            tick();
            mac_valid <= 1'b1;
            mac_beat  <= b;
            if (pass) begin
                b.bad            = 1'b0;
                exp_mem[exp_wr] <= b;
                exp_wr          <= exp_wr + 12'd1;
            end
        end
        if (pass) begin
            exp_good++;
        end else if (lost_for_space) begin
            exp_ovf++;
        end else begin
            exp_bad++;
        end
    endtask

    task automatic wait_pending(input logic [11:0] limit_beats, input int max_cycles);
        int n;
        n = 0;
        while (pending > limit_beats) begin
            if (n >= max_cycles) begin
                abort_run("Timed out waiting for expected beats at the output");
            end else begin
                tick();
                n++;
            end
        end
    endtask

    task automatic wait_status(input int max_cycles);
        int n;
        n = 0;
        while (good_pulses + bad_pulses + ovf_pulses < exp_good + exp_bad + exp_ovf) begin
            if (n >= max_cycles) begin
                abort_run("Timed out waiting for frame status pulses");
            end else begin
                tick();
                n++;
            end
        end
    endtask

    // Output monitor, consumes the model and counts status pulses
    always @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            exp_rd      <= '0;
            stall_q     <= 1'b0;
            held_beat   <= '0;
            good_pulses <= 0;
            bad_pulses  <= 0;
            ovf_pulses  <= 0;
        end else begin
            if (rx_valid && rx_ready && exp_present) begin
                exp_rd <= exp_rd + 12'd1;
            end
            stall_q   <= rx_valid && !rx_ready;
            held_beat <= rx_beat;
            if (rx_status.good_frame) begin
                good_pulses <= good_pulses + 1;
            end
            if (rx_status.bad_frame) begin
                bad_pulses <= bad_pulses + 1;
            end
            if (rx_status.overflow) begin
                ovf_pulses <= ovf_pulses + 1;
            end
        end
    end

    assert property (@(posedge logic_clk) disable iff (logic_rst)
        (rx_valid && rx_ready) |-> exp_present)
        else abort_run("Output beat arrived while no frame was expected");

    assert property (@(posedge logic_clk) disable iff (logic_rst)
        (rx_valid && rx_ready && exp_present) |-> (rx_beat == exp_head))
        else report_mismatch("output_beat", {54'd0, exp_head}, {54'd0, rx_beat});

    assert property (@(posedge logic_clk) disable iff (logic_rst)
        stall_q |-> rx_valid)
        else abort_run("rx_valid dropped while the output was stalled");

    assert property (@(posedge logic_clk) disable iff (logic_rst)
        stall_q |-> (rx_beat == held_beat))
        else report_mismatch("stall_hold", {54'd0, held_beat}, {54'd0, rx_beat});

    initial begin
        logic [63:0] r;
        int          len;
        mac_beat     = '0;
        mac_valid    = 1'b0;
        rx_ready     = 1'b1;
        exp_wr       = '0;
        exp_good     = 0;
        exp_bad      = 0;
        exp_ovf      = 0;
        random_ready = 1'b0;
        lfsr_state   = 16'd50;
        test_name    = "reset";
        apply_reset();
        idle_cycles(2);

        test_name = "good_frames";
        for (int f = 0; f < 20; f++) begin
            take_bits(5, r);
            len = int'(r[4:0]) % MAX_BEATS + 1;
            send_frame(len, 1'b0, 1'b0);
            take_bits(2, r);
            idle_cycles(int'(r[1:0]));
        end
        wait_pending(12'd0, 2000);
        wait_status(200);

        // Each flagged frame followed by a clean one
        test_name = "mac_bad_frames";
        for (int f = 0; f < 6; f++) begin
            take_bits(5, r);
            len = int'(r[4:0]) % MAX_BEATS + 1;
            send_frame(len, 1'b1, 1'b0);
            take_bits(5, r);
            len = int'(r[4:0]) % MAX_BEATS + 1;
            send_frame(len, 1'b0, 1'b0);
        end
        wait_pending(12'd0, 2000);
        wait_status(200);

        // Both length limits, then random lengths
        test_name = "oversize_frames";
        for (int f = 0; f < 4; f++) begin
            take_bits(4, r);
            len = (f == 0) ? 25 : (f == 1) ? 40 : 25 + int'(r[3:0]);
            send_frame(len, 1'b0, 1'b0);
            take_bits(5, r);
            send_frame(int'(r[4:0]) % MAX_BEATS + 1, 1'b0, 1'b0);
        end
        wait_pending(12'd0, 2000);
        wait_status(200);

        // Second frame cannot fit behind the first while the output is stalled
        test_name = "overflow";
        set_ready(1'b0);
        send_frame(MAX_BEATS, 1'b0, 1'b0);
        send_frame(MAX_BEATS, 1'b0, 1'b1);
        wait_status(200);
        check_count("overflow_pulses", 1, ovf_pulses);
        idle_cycles(10);
        set_ready(1'b1);
        wait_pending(12'd0, 2000);

        test_name    = "random_backpressure";
        random_ready = 1'b1;
        for (int f = 0; f < 30; f++) begin
            wait_pending(12'd4, 2000);
            take_bits(5, r);
            len = int'(r[4:0]) % MAX_BEATS + 1;
            send_frame(len, 1'b0, 1'b0);
            take_bits(2, r);
            idle_cycles(int'(r[1:0]));
        end
        wait_pending(12'd0, 4000);
        random_ready = 1'b0;
        set_ready(1'b1);

        test_name = "end_of_run";
        wait_status(200);
        idle_cycles(4);
        check_count("good_frame_pulses", exp_good, good_pulses);
        check_count("bad_frame_pulses", exp_bad, bad_pulses);
        check_count("overflow_pulses", exp_ovf, ovf_pulses);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
